// File: sim/imuldiv_patterns.hex
// func a b expected, func 0 mul, 1 mulu, 2 div, 3 divu
// divide results are {rem, quot}, func ff ends the list
0 00000000 00000000 0000000000000000
0 00000003 00000007 0000000000000015
0 fffffffd 00000007 ffffffffffffffeb
0 00000007 fffffffd ffffffffffffffeb
0 fffffffd fffffff9 0000000000000015
0 ffffffff 00000000 0000000000000000
0 80000000 80000000 4000000000000000
0 80000000 7fffffff c000000080000000
0 7fffffff 7fffffff 3fffffff00000001
0 ffffffff ffffffff 0000000000000001
0 80000000 ffffffff 0000000080000000
0 12345678 00000010 0000000123456780
1 ffffffff ffffffff fffffffe00000001
1 ffffffff 00000002 00000001fffffffe
1 80000000 80000000 4000000000000000
1 fffffffd 00000007 00000006ffffffeb
1 00000000 ffffffff 0000000000000000
1 00010000 00010000 0000000100000000
1 0000ffff 0000ffff 00000000fffe0001
1 deadbeef 00000001 00000000deadbeef
2 00000014 00000003 0000000200000006
2 ffffffec 00000003 fffffffefffffffa
2 00000014 fffffffd 00000002fffffffa
2 ffffffec fffffffd fffffffe00000006
2 80000000 ffffffff 0000000080000000
2 00000007 00000000 00000007ffffffff
2 fffffff9 00000000 fffffff9ffffffff
2 00000000 00000005 0000000000000000
2 00000003 00000007 0000000300000000
2 7fffffff 00000001 000000007fffffff
2 80000000 00000002 00000000c0000000
2 80000000 80000000 0000000000000001
3 ffffffff 00000010 0000000f0fffffff
3 ffffffec 00000003 000000025555554e
3 12345678 00000000 12345678ffffffff
3 80000000 ffffffff 8000000000000000
3 deadbeef 00010000 0000beef0000dead
3 00000064 0000000a 000000000000000a
0 00000005 fffffffb ffffffffffffffe7
3 00000011 00000005 0000000200000003
1 00000100 00000100 0000000000010000
2 ffffffef 00000005 fffffffefffffffd
ff 00000000 00000000 0000000000000000

// File: compile.f
+incdir+design
design/imuldiv_pkg.sv
design/imuldiv_mul_iterative.sv
design/imuldiv_div_iterative.sv
design/imuldiv_unit.sv
sim/imuldiv_unit_tb.sv

// File: Makefile
# Verilator build and run for the mul/div unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = imuldiv_unit_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal, status comes from the search
run: compile
	$(SIM_BIN) | tee /dev/stderr | grep -Fx "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: sim/imuldiv_unit_tb.sv
// ----------------------------------------------------------------------
// testbench for the mul/div unit
// pattern file stimulus with random response back-pressure
// checks results, latency and the request/response handshake
// ----------------------------------------------------------------------

module imuldiv_unit_tb import imuldiv_pkg::*; ();

  localparam int          MAX_OPS   = 64;
  localparam int          PAT_WORDS = 4 * MAX_OPS;
  // 32 iteration cycles plus the sign fix cycle
  localparam int          LATENCY   = 33;
  localparam int          TIMEOUT   = 200;
  localparam logic [63:0] END_MARK  = 64'hff;

  logic            clk;
  logic            reset;
  imuldiv_req_t    req;
  logic            req_val;
  logic            req_rdy;
  imuldiv_result_u resp;
  logic            resp_val;
  logic            resp_rdy;

  // four words per operation with func, a, b and the expected result
  logic [63:0]     pat_mem [0:PAT_WORDS-1];
  logic [31:0]     lcg_state;
  int              num_ops;

  imuldiv_unit i_imuldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  // 32-bit LCG with the numerical recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // request fields of one pattern line
  function automatic imuldiv_req_t pattern_req(input int idx);
    imuldiv_req_t r;
    r.func = imuldiv_func_e'(pat_mem[4*idx][1:0]);
    r.a    = pat_mem[4*idx+1][31:0];
    r.b    = pat_mem[4*idx+2][31:0];
    return r;
  endfunction

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
      stop_on_error();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_on_error();
  endtask

  // ----------------------------------------------------------------------
  // one operation from request through release
  // ----------------------------------------------------------------------

  task automatic run_op(input int idx);
    imuldiv_req_t    r;
    imuldiv_result_u expected;
    imuldiv_result_u held;
    int              gap;
    int              hold;
    logic            early;
    int              waited;

    r                = pattern_req(idx);
    expected.product = pat_mem[4*idx+3];
    // upper LCG bits since the low ones cycle quickly
    gap   = int'(next_rand() >> 16) % 4;
    hold  = int'(next_rand() >> 16) % 8;
    // next request offered during back-pressure goes back to back
    early = ((int'(next_rand() >> 16) % 2) == 1) && (idx + 1 < num_ops);

    // a request offered early by the previous operation is already on req
    if (!req_val) begin
      // idle cycles between requests
      repeat (gap) @(posedge clk);
      @(posedge clk);
      req     <= r;
      req_val <= 1'b1;
      @(negedge clk);
    end

    waited = 0;
    while (!req_rdy) begin
      if (waited == TIMEOUT) begin
        report_timeout("req_rdy");
      end
      waited++;
      @(negedge clk);
    end

    // transfer happens on this edge
    @(posedge clk);
    req_val <= 1'b0;
    // scramble the payload since the unit holds its own copy
    req.a   <= next_rand();
    req.b   <= next_rand();

    // count edges from the transfer to resp_val
    waited = 0;
    @(negedge clk);
    while (!resp_val) begin
      check_val("req_rdy", 64'(req_rdy), 64'h0);
      if (waited == TIMEOUT) begin
        report_timeout("resp_val");
      end
      waited++;
      @(negedge clk);
    end
    check_val("latency", 64'(waited), 64'(LATENCY));
    check_val("req_rdy", 64'(req_rdy), 64'h0);

    // read the view that matches the function
    held = resp;
    if (r.func[1]) begin
      check_val("resp.div.quot", 64'(held.div.quot), 64'(expected.div.quot));
      check_val("resp.div.rem", 64'(held.div.rem), 64'(expected.div.rem));
    end else begin
      check_val("resp.product", held.product, expected.product);
    end

    // next request waits while this response is pending
    if (early) begin
      @(posedge clk);
      req     <= pattern_req(idx + 1);
      req_val <= 1'b1;
    end

    // result sits still under back-pressure
    repeat (hold) begin
      @(negedge clk);
      check_val("resp_val", 64'(resp_val), 64'h1);
      check_val("resp", resp.product, held.product);
      check_val("req_rdy", 64'(req_rdy), 64'h0);
    end

    @(posedge clk);
    resp_rdy <= 1'b1;
    @(negedge clk);
    check_val("resp_val", 64'(resp_val), 64'h1);
    check_val("resp", resp.product, held.product);
    check_val("req_rdy", 64'(req_rdy), 64'h0);

    // response transfers on this edge and the unit is free right after
    @(posedge clk);
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_val("resp_val", 64'(resp_val), 64'h0);
    check_val("req_rdy", 64'(req_rdy), 64'h1);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial begin
    int idx;

    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    lcg_state = 32'hc791_5cc1;
    num_ops   = 0;

    $readmemh("sim/imuldiv_patterns.hex", pat_mem);
    // operations run up to the end marker line
    while (num_ops < MAX_OPS && pat_mem[4*num_ops] !== END_MARK) begin
      num_ops++;
    end
    if (num_ops == MAX_OPS || num_ops == 0) begin
      $display("pattern file has no end marker or no operations");
      stop_on_error();
    end
    $display("running %0d operations", num_ops);

    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // idle state right after reset
    @(negedge clk);
    check_val("req_rdy", 64'(req_rdy), 64'h1);
    check_val("resp_val", 64'(resp_val), 64'h0);

    for (idx = 0; idx < num_ops; idx++) begin
      run_op(idx);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: design/imuldiv_unit.sv
// ---------------------------------------------------------------------
// mul/div unit top: routes each request to the multiplier or divider,
// one operation in flight, response muxed from the busy unit
// ---------------------------------------------------------------------

module imuldiv_unit import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  imuldiv_req_t    req,
  input  logic            req_val,
  output logic            req_rdy,
  output imuldiv_result_u resp,
  output logic            resp_val,
  input  logic            resp_rdy
);

  logic            mul_req_val;
  logic            mul_req_rdy;
  imuldiv_result_u mul_resp;
  logic            mul_resp_val;
  logic            mul_resp_rdy;

  logic            div_req_val;
  logic            div_req_rdy;
  imuldiv_result_u div_resp;
  logic            div_resp_val;
  logic            div_resp_rdy;

  // operation in flight and which unit owns it
  logic            busy_q;
  logic            busy_div_q;

  // ---------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------

  // accept only with both units idle and nothing pending
  assign req_rdy     = mul_req_rdy & div_req_rdy & ~busy_q;
  // func bit 1 picks the divider
  assign mul_req_val = req_val & req_rdy & ~req.func[1];
  assign div_req_val = req_val & req_rdy &  req.func[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q     <= 1'b0;
      busy_div_q <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy_q     <= 1'b1;
      busy_div_q <= req.func[1];
    end else if (resp_val && resp_rdy) begin
      busy_q <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // units
  // ---------------------------------------------------------------------

  imuldiv_mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_div_iterative i_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  // ---------------------------------------------------------------------
  // response side
  // ---------------------------------------------------------------------

  assign resp     = busy_div_q ? div_resp : mul_resp;
  assign resp_val = busy_q & (busy_div_q ? div_resp_val : mul_resp_val);

  // ready goes back to the owning unit only
  assign mul_resp_rdy = resp_rdy & busy_q & ~busy_div_q;
  assign div_resp_rdy = resp_rdy & busy_q &  busy_div_q;

  a_one_resp: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

// File: design/imuldiv_div_iterative.sv
// ---------------------------------------------------------------------
// iterative divider: restoring shift-and-subtract over 32 cycles
// returns remainder and quotient, signed or unsigned
// ---------------------------------------------------------------------

`include "imuldiv_params.svh"

// ---------------------------------------------------------------------
// datapath
// ---------------------------------------------------------------------

module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  imuldiv_req_t    req,
  input  logic            a_en,
  input  logic            a_sel,
  input  logic            b_en,
  input  logic            b_sel,
  input  logic            fix_sign,
  output logic            rem_neg,
  output imuldiv_result_u result
);

  localparam int XLEN = `IMULDIV_XLEN;

  logic [XLEN-1:0]   divisor_q;
  imuldiv_result_u   rq_q;
  logic              q_neg_q;
  logic              r_neg_q;

  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic              b_zero;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [XLEN:0]     rem_shift;
  logic [XLEN+1:0]   diff;

  assign is_signed = ~req.func[0];
  assign a_neg     = is_signed & req.a[XLEN-1];
  assign b_neg     = is_signed & req.b[XLEN-1];
  assign b_zero    = (req.b == '0);
  assign a_mag     = a_neg ? -req.a : req.a;
  assign b_mag     = b_neg ? -req.b : req.b;

  // remainder shifted left, next dividend bit comes in from the quotient msb
  assign rem_shift = {rq_q.div.rem, rq_q.div.quot[XLEN-1]};
  // trial subtract, one extra bit for the sign
  assign diff      = {1'b0, rem_shift} - {2'b00, divisor_q};
  assign rem_neg   = diff[XLEN+1];

  assign result = rq_q;

  // result signs, recorded at load
  always_ff @(posedge clk) begin
    if (reset) begin
      q_neg_q <= 1'b0;
      r_neg_q <= 1'b0;
    end else if (b_en) begin
      // a zero divisor keeps the all-ones quotient unsigned
      q_neg_q <= (a_neg ^ b_neg) & ~b_zero;
      // remainder follows the dividend
      r_neg_q <= a_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (b_en) begin
      divisor_q <= b_mag;
    end
    if (a_en && !a_sel) begin
      rq_q.div.rem  <= '0;
      rq_q.div.quot <= a_mag;
    end else if (a_en) begin
      // b_sel keeps the difference and sets the quotient bit
      rq_q.div.rem  <= b_sel ? diff[XLEN-1:0] : rem_shift[XLEN-1:0];
      rq_q.div.quot <= {rq_q.div.quot[XLEN-2:0], b_sel};
    end else if (fix_sign) begin
      if (r_neg_q) begin
        rq_q.div.rem <= -rq_q.div.rem;
      end
      if (q_neg_q) begin
        rq_q.div.quot <= -rq_q.div.quot;
      end
    end
  end

endmodule

// ---------------------------------------------------------------------
// control
// ---------------------------------------------------------------------

module imuldiv_div_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic rem_neg,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic fix_sign
);

  localparam logic [`IMULDIV_CNT_W-1:0] CNT_LAST = `IMULDIV_CNT_W'(`IMULDIV_XLEN);

  imuldiv_state_e              state_q;
  logic [`IMULDIV_CNT_W-1:0]   count_q;
  logic                        last;

  assign last = (count_q == CNT_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_val && req_rdy) begin
            state_q <= ST_CALC;
            count_q <= '0;
          end
        end
        ST_CALC: begin
          if (last) begin
            state_q <= ST_DONE;
            count_q <= '0;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
        ST_DONE: begin
          if (resp_val && resp_rdy) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    a_en     = 1'b0;
    a_sel    = 1'b0;
    b_en     = 1'b0;
    b_sel    = 1'b0;
    fix_sign = 1'b0;
    case (state_q)
      ST_IDLE: begin
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
      end
      ST_CALC: begin
        if (last) begin
          fix_sign = 1'b1;
        end else begin
          // divisor holds, rem/quot steps
          a_en  = 1'b1;
          a_sel = 1'b1;
          // negative trial restores, otherwise subtract
          b_sel = ~rem_neg;
        end
      end
      ST_DONE: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

  // no more than 32 restoring steps per operation
  a_step_count: assert property (@(posedge clk) disable iff (reset)
    (a_en && a_sel) |-> (count_q <= `IMULDIV_CNT_W'(`IMULDIV_XLEN - 1)));

endmodule

// ---------------------------------------------------------------------
// wrapper
// ---------------------------------------------------------------------

module imuldiv_div_iterative import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  imuldiv_req_t    req,
  input  logic            req_val,
  output logic            req_rdy,
  output imuldiv_result_u resp,
  output logic            resp_val,
  input  logic            resp_rdy
);

  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic fix_sign;
  logic rem_neg;

  imuldiv_div_dpath i_dpath (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .a_en     (a_en),
    .a_sel    (a_sel),
    .b_en     (b_en),
    .b_sel    (b_sel),
    .fix_sign (fix_sign),
    .rem_neg  (rem_neg),
    .result   (resp)
  );

  imuldiv_div_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .rem_neg  (rem_neg),
    .a_en     (a_en),
    .a_sel    (a_sel),
    .b_en     (b_en),
    .b_sel    (b_sel),
    .fix_sign (fix_sign)
  );

endmodule

// File: design/imuldiv_mul_iterative.sv
// ---------------------------------------------------------------------
// iterative multiplier: shift-and-add over 32 cycles, signed or unsigned
// ---------------------------------------------------------------------

`include "imuldiv_params.svh"

// ---------------------------------------------------------------------
// datapath
// ---------------------------------------------------------------------

module imuldiv_mul_dpath import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  imuldiv_req_t    req,
  input  logic            a_en,
  input  logic            a_sel,
  input  logic            b_en,
  input  logic            b_sel,
  input  logic            fix_sign,
  output logic            b_lsb,
  output imuldiv_result_u result
);

  localparam int XLEN = `IMULDIV_XLEN;

  logic [2*XLEN-1:0] a_q;
  logic [XLEN-1:0]   b_q;
  imuldiv_result_u   acc_q;
  logic              neg_q;

  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;

  // func bit 0 clear means signed
  assign is_signed = ~req.func[0];
  assign a_neg     = is_signed & req.a[XLEN-1];
  assign b_neg     = is_signed & req.b[XLEN-1];
  assign a_mag     = a_neg ? -req.a : req.a;
  assign b_mag     = b_neg ? -req.b : req.b;

  // multiplier lsb decides the add
  assign b_lsb  = b_q[0];
  assign result = acc_q;

  // result sign, recorded at load
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_q <= 1'b0;
    end else if (a_en && !a_sel) begin
      neg_q <= a_neg ^ b_neg;
    end
  end

  always_ff @(posedge clk) begin
    // multiplicand shifts left, zero extended to 64 bits
    if (a_en) begin
      a_q <= a_sel ? (a_q << 1) : {{XLEN{1'b0}}, a_mag};
    end
    // multiplier shifts right
    if (b_en) begin
      b_q <= b_sel ? (b_q >> 1) : b_mag;
    end
    // accumulator: clear on load, add on set lsb, negate at the end
    if (a_en && !a_sel) begin
      acc_q.product <= '0;
    end else if (a_en) begin
      if (b_lsb) begin
        acc_q.product <= acc_q.product + a_q;
      end
    end else if (fix_sign && neg_q) begin
      acc_q.product <= -acc_q.product;
    end
  end

endmodule

// ---------------------------------------------------------------------
// control
// ---------------------------------------------------------------------

module imuldiv_mul_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_sel,
  output logic b_en,
  output logic b_sel,
  output logic fix_sign
);

  // count XLEN marks the sign fix cycle
  localparam logic [`IMULDIV_CNT_W-1:0] CNT_LAST = `IMULDIV_CNT_W'(`IMULDIV_XLEN);

  imuldiv_state_e              state_q;
  logic [`IMULDIV_CNT_W-1:0]   count_q;
  logic                        last;

  assign last = (count_q == CNT_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_val && req_rdy) begin
            state_q <= ST_CALC;
            count_q <= '0;
          end
        end
        ST_CALC: begin
          if (last) begin
            state_q <= ST_DONE;
            count_q <= '0;
          end else begin
            count_q <= count_q + 1'b1;
          end
        end
        ST_DONE: begin
          // hold the result until the consumer takes it
          if (resp_val && resp_rdy) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    a_en     = 1'b0;
    a_sel    = 1'b0;
    b_en     = 1'b0;
    b_sel    = 1'b0;
    fix_sign = 1'b0;
    case (state_q)
      ST_IDLE: begin
        // load operand magnitudes on accept
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
      end
      ST_CALC: begin
        if (last) begin
          fix_sign = 1'b1;
        end else begin
          a_en  = 1'b1;
          a_sel = 1'b1;
          b_en  = 1'b1;
          b_sel = 1'b1;
        end
      end
      ST_DONE: begin
        resp_val = 1'b1;
      end
      default: ;
    endcase
  end

  a_no_rdy_while_resp: assert property (@(posedge clk) disable iff (reset)
    !(resp_val && req_rdy));

endmodule

// ---------------------------------------------------------------------
// wrapper
// ---------------------------------------------------------------------

module imuldiv_mul_iterative import imuldiv_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  imuldiv_req_t    req,
  input  logic            req_val,
  output logic            req_rdy,
  output imuldiv_result_u resp,
  output logic            resp_val,
  input  logic            resp_rdy
);

  logic a_en;
  logic a_sel;
  logic b_en;
  logic b_sel;
  logic fix_sign;
  logic b_lsb;

  imuldiv_mul_dpath i_dpath (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .a_en     (a_en),
    .a_sel    (a_sel),
    .b_en     (b_en),
    .b_sel    (b_sel),
    .fix_sign (fix_sign),
    .b_lsb    (b_lsb),
    .result   (resp)
  );

  imuldiv_mul_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .a_en     (a_en),
    .a_sel    (a_sel),
    .b_en     (b_en),
    .b_sel    (b_sel),
    .fix_sign (fix_sign)
  );

  // all 32 multiplier bits are consumed before the response
  a_mplier_drained: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> !b_lsb);

endmodule

// File: design/imuldiv_pkg.sv
// ---------------------------------------------------------------------
// mul/div unit types: function codes, request, result views, FSM states
// ---------------------------------------------------------------------

`include "imuldiv_params.svh"

package imuldiv_pkg;

  // bit 1 picks the divider, bit 0 marks an unsigned operation
  typedef enum logic [1:0] {
    FUNC_MUL  = 2'b00,
    FUNC_MULU = 2'b01,
    FUNC_DIV  = 2'b10,
    FUNC_DIVU = 2'b11
  } imuldiv_func_e;

  // request payload, 2 + 32 + 32 bits
  typedef struct packed {
    imuldiv_func_e             func;
    logic [`IMULDIV_XLEN-1:0]  a;
    logic [`IMULDIV_XLEN-1:0]  b;
  } imuldiv_req_t;

  // divider view of the result word
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0]  rem;
    logic [`IMULDIV_XLEN-1:0]  quot;
  } imuldiv_divres_t;

  // one 64-bit result word
  // multiplier fills product, divider fills rem/quot
  typedef union packed {
    logic [2*`IMULDIV_XLEN-1:0] product;
    imuldiv_divres_t            div;
  } imuldiv_result_u;

  // states shared by both iterative control units
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } imuldiv_state_e;

endpackage

// File: design/imuldiv_params.svh
// ---------------------------------------------------------------------
// mul/div unit parameters
// operand width and iteration counter width
// ---------------------------------------------------------------------

`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// operand width, one iteration per bit
`define IMULDIV_XLEN 32

// iteration counter width
// must hold the value XLEN, the counter's sign fix step
`define IMULDIV_CNT_W 6

`endif
